// File: include/dram_cfg.svh
// DRAM model sizing macros
`ifndef DRAM_CFG_SVH
`define DRAM_CFG_SVH

// --------------------
// Command bus
// --------------------
`define DRAM_ADDR_W 8
`define DRAM_BANK_W 2

// Location fields
// Row taken from the low address bits at activate
`define DRAM_ROW_W 4
// Column taken from the low address bits at read and write
`define DRAM_COL_W 6

// --------------------
// Data path
// --------------------
`define DRAM_DATA_W 64
`define DRAM_ECC_W 8
`define DRAM_WORD_W 72

// Beat slots in each latency queue
`define DRAM_SLOT_DEPTH 32

`endif

// File: hdl/dram_mode_pkg.sv
// DRAM mode register types
package dram_mode_pkg;

	// --------------------
	// Mode register fields
	// --------------------

	// Burst length code from addr[2:0]
	// Codes above bl_4 behave as bl_4
	typedef enum logic [2:0] {
		bl_1 = 3'd0,
		bl_2 = 3'd1,
		bl_4 = 3'd2
	} burst_code_e;

	// Mode register target, taken from the bank bits
	typedef enum logic [1:0] {
		mode_timing = 2'd0,
		mode_align  = 2'd1
	} mode_sel_e;

	// CAS latency from addr[6:4], alignment from addr[5:3]
	typedef logic [2:0] cas_lat_t;
	typedef logic [2:0] align_lat_t;

	// Values after reset
	localparam burst_code_e burst_rst = bl_4;
	localparam cas_lat_t    cas_rst   = 3'd2;
	localparam align_lat_t  align_rst = 3'd0;

endpackage

// File: hdl/dram_cmd_pkg.sv
// DRAM command bus types
`include "dram_cfg.svh"

package dram_cmd_pkg;

	// --------------------
	// Decoded command
	// --------------------
	typedef enum logic [2:0] {
		cmd_nop,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_mode_set
	} dram_cmd_e;

	// One storage word with check bits on top
	typedef struct packed {
		logic [`DRAM_ECC_W-1:0]  ecc;
		logic [`DRAM_DATA_W-1:0] data;
	} dram_word_t;

	// 12-bit storage location
	// Bank in the low bits
	typedef struct packed {
		logic [`DRAM_ROW_W-1:0]  row;
		logic [`DRAM_COL_W-1:0]  col;
		logic [`DRAM_BANK_W-1:0] bank;
	} dram_loc_t;

endpackage

// File: hdl/dram_array.sv
// DRAM word storage
`include "dram_cfg.svh"

module dram_array (
	input  logic                     clk,
	input  logic                     rd_en,
	input  dram_cmd_pkg::dram_loc_t  rd_loc,
	input  logic                     wr_en,
	input  dram_cmd_pkg::dram_loc_t  wr_loc,
	input  dram_cmd_pkg::dram_word_t wr_data,
	output dram_cmd_pkg::dram_word_t rd_data
);

	// One word per row, column and bank
	localparam int depth = 1 << $bits(dram_cmd_pkg::dram_loc_t);

	logic [`DRAM_WORD_W-1:0] mem [depth];

	// Unwritten words read back as zero
	initial
	begin
		for (int i = 0; i < depth; i++)
		begin
			mem[i] = '0;
		end
	end

	// --------------------
	// Write port
	// --------------------
	always @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_loc] <= wr_data;
		end
	end

	// Combinational read port
	assign rd_data = rd_en ? mem[rd_loc] : '0;

endmodule

// File: hdl/dram_cmd_decode.sv
// DRAM command decoder
`include "dram_cfg.svh"

module dram_cmd_decode (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cs_n,
	input  logic                    ras_n,
	input  logic                    cas_n,
	input  logic                    we_n,
	input  logic [`DRAM_BANK_W-1:0] ba,
	input  logic [`DRAM_ADDR_W-1:0] addr,
	output logic                    cmd_valid,
	output dram_cmd_pkg::dram_cmd_e cmd,
	output dram_cmd_pkg::dram_loc_t loc,
	output logic [3:0]              burst_len,
	output logic [3:0]              read_lat,
	output logic [3:0]              write_lat
);

	localparam int bank_cnt = 1 << `DRAM_BANK_W;

	// Registered command bus
	logic                    cs_n_q;
	logic                    ras_n_q;
	logic                    cas_n_q;
	logic                    we_n_q;
	logic [`DRAM_BANK_W-1:0] ba_q;
	logic [`DRAM_ADDR_W-1:0] addr_q;

	dram_cmd_pkg::dram_cmd_e cmd_dec;

	// Open row per bank
	logic [`DRAM_ROW_W-1:0] row_q [bank_cnt];

	// Mode fields
	dram_mode_pkg::burst_code_e burst_code_q;
	dram_mode_pkg::cas_lat_t    cas_lat_q;
	dram_mode_pkg::align_lat_t  align_lat_q;

	// --------------------
	// Capture edge
	// --------------------
	// Strobes idle high so reset decodes as nop
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cs_n_q  <= 1'b1;
			ras_n_q <= 1'b1;
			cas_n_q <= 1'b1;
			we_n_q  <= 1'b1;
		end
		else
		begin
			cs_n_q  <= cs_n;
			ras_n_q <= ras_n;
			cas_n_q <= cas_n;
			we_n_q  <= we_n;
		end
	end

	// Bank and address capture
	always_ff @(posedge clk)
	begin
		ba_q   <= ba;
		addr_q <= addr;
	end

	// --------------------
	// Decode
	// --------------------
	always_comb
	begin
		case ({cs_n_q, ras_n_q, cas_n_q, we_n_q})
			4'b0101: cmd_dec = dram_cmd_pkg::cmd_read;
			4'b0100: cmd_dec = dram_cmd_pkg::cmd_write;
			4'b0011: cmd_dec = dram_cmd_pkg::cmd_activate;
			4'b0000: cmd_dec = dram_cmd_pkg::cmd_mode_set;
			// Deselect and precharge/refresh fall here
			default: cmd_dec = dram_cmd_pkg::cmd_nop;
		endcase
	end

	// --------------------
	// Row and mode state
	// --------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < bank_cnt; i++)
			begin
				row_q[i] <= '0;
			end
			burst_code_q <= dram_mode_pkg::burst_rst;
			cas_lat_q    <= dram_mode_pkg::cas_rst;
			align_lat_q  <= dram_mode_pkg::align_rst;
		end
		else
		begin
			case (cmd_dec)
				// Latch row for this bank
				dram_cmd_pkg::cmd_activate: row_q[ba_q] <= addr_q[`DRAM_ROW_W-1:0];
				dram_cmd_pkg::cmd_mode_set:
				begin
					// Bank bits pick the register
					case (dram_mode_pkg::mode_sel_e'(ba_q))
						dram_mode_pkg::mode_timing:
						begin
							burst_code_q <= dram_mode_pkg::burst_code_e'(addr_q[2:0]);
							cas_lat_q    <= addr_q[6:4];
						end
						dram_mode_pkg::mode_align: align_lat_q <= addr_q[5:3];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// --------------------
	// Scheduler request
	// --------------------
	always_comb
	begin
		case (burst_code_q)
			dram_mode_pkg::bl_1: burst_len = 4'd1;
			dram_mode_pkg::bl_2: burst_len = 4'd2;
			default:             burst_len = 4'd4;
		endcase
	end

	assign read_lat  = {1'b0, align_lat_q} + {1'b0, cas_lat_q};
	assign write_lat = read_lat - 4'd1;

	// Only column accesses reach the scheduler
	assign cmd_valid = (cmd_dec == dram_cmd_pkg::cmd_read) ||
		(cmd_dec == dram_cmd_pkg::cmd_write);
	assign cmd = cmd_dec;

	// Row comes from the bank's open row
	assign loc.row  = row_q[ba_q];
	assign loc.col  = addr_q[`DRAM_COL_W-1:0];
	assign loc.bank = ba_q;

endmodule

// File: hdl/dram_burst_sched.sv
// DRAM burst slot scheduler
`include "dram_cfg.svh"

module dram_burst_sched (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     cmd_valid,
	input  dram_cmd_pkg::dram_cmd_e  cmd,
	input  dram_cmd_pkg::dram_loc_t  loc,
	input  logic [3:0]               burst_len,
	input  logic [3:0]               read_lat,
	input  logic [3:0]               write_lat,
	input  logic [`DRAM_DATA_W-1:0]  dq_in,
	input  logic [`DRAM_ECC_W-1:0]   ecc_in,
	output logic                     rd_en,
	output dram_cmd_pkg::dram_loc_t  rd_loc,
	input  dram_cmd_pkg::dram_word_t rd_data,
	output logic                     wr_en,
	output dram_cmd_pkg::dram_loc_t  wr_loc,
	output dram_cmd_pkg::dram_word_t wr_data,
	output logic [`DRAM_DATA_W-1:0]  dq_out,
	output logic [`DRAM_ECC_W-1:0]   ecc_out,
	output logic                     dq_oe,
	output logic                     dqs_out,
	output logic                     dqs_oe
);

	localparam int depth     = `DRAM_SLOT_DEPTH;
	localparam int slot_w    = $clog2(`DRAM_SLOT_DEPTH);
	localparam int max_burst = 4;

	// Slot queues with slot 0 at the head
	logic [depth-1:0]        rd_valid_q;
	logic [depth-1:0]        rd_valid_nxt;
	logic [depth-1:0]        wr_valid_q;
	logic [depth-1:0]        wr_valid_nxt;
	dram_cmd_pkg::dram_loc_t rd_loc_q   [depth];
	dram_cmd_pkg::dram_loc_t rd_loc_nxt [depth];
	dram_cmd_pkg::dram_loc_t wr_loc_q   [depth];
	dram_cmd_pkg::dram_loc_t wr_loc_nxt [depth];

	// Beat address with the low two column bits wrapped
	function automatic dram_cmd_pkg::dram_loc_t beat_loc(
		input dram_cmd_pkg::dram_loc_t start,
		input logic [1:0]              beat
	);
		dram_cmd_pkg::dram_loc_t l;
		l = start;
		l.col[1:0] = start.col[1:0] + beat;
		return l;
	endfunction

	// --------------------
	// Shift and fill
	// --------------------
	always_comb
	begin
		logic [3:0]        base;
		logic [slot_w-1:0] idx;

		// Everything moves one slot toward the head
		rd_valid_nxt = {1'b0, rd_valid_q[depth-1:1]};
		wr_valid_nxt = {1'b0, wr_valid_q[depth-1:1]};
		for (int i = 0; i < depth - 1; i++)
		begin
			rd_loc_nxt[i] = rd_loc_q[i+1];
			wr_loc_nxt[i] = wr_loc_q[i+1];
		end
		rd_loc_nxt[depth-1] = '0;
		wr_loc_nxt[depth-1] = '0;

		// Slot n of a burst sits at latency + n
		// Newer command overwrites an occupied slot
		base = (cmd == dram_cmd_pkg::cmd_read) ? read_lat : write_lat;
		idx  = '0;
		if (cmd_valid)
		begin
			for (int n = 0; n < max_burst; n++)
			begin
				if (n < burst_len)
				begin
					idx = slot_w'(base) + slot_w'(n);
					if (cmd == dram_cmd_pkg::cmd_read)
					begin
						rd_valid_nxt[idx] = 1'b1;
						rd_loc_nxt[idx]   = beat_loc(loc, 2'(n));
					end
					else
					begin
						wr_valid_nxt[idx] = 1'b1;
						wr_loc_nxt[idx]   = beat_loc(loc, 2'(n));
					end
				end
			end
		end
	end

	// --------------------
	// Queue and strobe state
	// --------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_valid_q <= '0;
			wr_valid_q <= '0;
			dq_oe      <= 1'b0;
			dqs_oe     <= 1'b0;
			dqs_out    <= 1'b0;
		end
		else
		begin
			rd_valid_q <= rd_valid_nxt;
			wr_valid_q <= wr_valid_nxt;
			// Head beat drives the bus next cycle
			dq_oe <= rd_valid_q[0];
			// Beat at the head next means preamble now
			dqs_oe <= rd_valid_q[0] | rd_valid_nxt[0];
			// One toggle per beat and parked low otherwise
			dqs_out <= rd_valid_q[0] ? ~dqs_out : 1'b0;
		end
	end

	// Slot locations follow the valid bits
	always_ff @(posedge clk)
	begin
		rd_loc_q <= rd_loc_nxt;
		wr_loc_q <= wr_loc_nxt;
	end

	// --------------------
	// Array access at the head
	// --------------------
	assign rd_en  = rd_valid_q[0];
	assign rd_loc = rd_loc_q[0];

	// Read word captured onto the data outputs
	always_ff @(posedge clk)
	begin
		if (rd_valid_q[0])
		begin
			dq_out  <= rd_data.data;
			ecc_out <= rd_data.ecc;
		end
	end

	// Write beat samples the bus at the array's edge
	assign wr_en        = wr_valid_q[0];
	assign wr_loc       = wr_loc_q[0];
	assign wr_data.data = dq_in;
	assign wr_data.ecc  = ecc_in;

endmodule

// File: hdl/dram_model_top.sv
// DRAM model top level
`include "dram_cfg.svh"

module dram_model_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cs_n,
	input  logic                    ras_n,
	input  logic                    cas_n,
	input  logic                    we_n,
	input  logic [`DRAM_BANK_W-1:0] ba,
	input  logic [`DRAM_ADDR_W-1:0] addr,
	input  logic [`DRAM_DATA_W-1:0] dq_in,
	input  logic [`DRAM_ECC_W-1:0]  ecc_in,
	output logic [`DRAM_DATA_W-1:0] dq_out,
	output logic [`DRAM_ECC_W-1:0]  ecc_out,
	output logic                    dq_oe,
	output logic                    dqs_out,
	output logic                    dqs_oe
);

	// Decoder to scheduler
	logic                    cmd_valid;
	dram_cmd_pkg::dram_cmd_e cmd;
	dram_cmd_pkg::dram_loc_t loc;
	logic [3:0]              burst_len;
	logic [3:0]              read_lat;
	logic [3:0]              write_lat;

	// Scheduler to array
	logic                     rd_en;
	dram_cmd_pkg::dram_loc_t  rd_loc;
	dram_cmd_pkg::dram_word_t rd_data;
	logic                     wr_en;
	dram_cmd_pkg::dram_loc_t  wr_loc;
	dram_cmd_pkg::dram_word_t wr_data;

	// --------------------
	// Command decode
	// --------------------
	dram_cmd_decode u_dram_cmd_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.cs_n      (cs_n),
		.ras_n     (ras_n),
		.cas_n     (cas_n),
		.we_n      (we_n),
		.ba        (ba),
		.addr      (addr),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.loc       (loc),
		.burst_len (burst_len),
		.read_lat  (read_lat),
		.write_lat (write_lat)
	);

	// --------------------
	// Beat slots and pins
	// --------------------
	dram_burst_sched u_dram_burst_sched (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.loc       (loc),
		.burst_len (burst_len),
		.read_lat  (read_lat),
		.write_lat (write_lat),
		.dq_in     (dq_in),
		.ecc_in    (ecc_in),
		.rd_en     (rd_en),
		.rd_loc    (rd_loc),
		.rd_data   (rd_data),
		.wr_en     (wr_en),
		.wr_loc    (wr_loc),
		.wr_data   (wr_data),
		.dq_out    (dq_out),
		.ecc_out   (ecc_out),
		.dq_oe     (dq_oe),
		.dqs_out   (dqs_out),
		.dqs_oe    (dqs_oe)
	);

	// Storage
	dram_array u_dram_array (
		.clk     (clk),
		.rd_en   (rd_en),
		.rd_loc  (rd_loc),
		.wr_en   (wr_en),
		.wr_loc  (wr_loc),
		.wr_data (wr_data),
		.rd_data (rd_data)
	);

endmodule

// File: testbench/dram_model_props.sv
// DRAM strobe ordering checks
module dram_model_props (
	input logic clk,
	input logic arst_n,
	input logic dq_oe,
	input logic dqs_oe,
	input logic dqs_out
);

	// Count of failed checks
	int fail_count = 0;

	// --------------------
	// Enable ordering
	// --------------------
	// Data never driven without the strobe
	a_dq_needs_dqs: assert property (@(posedge clk) disable iff (!arst_n) dq_oe |-> dqs_oe)
	else
	begin
		$error("dq_oe high while dqs_oe is low");
		fail_count++;
	end

	// Strobe alone means preamble with the first beat next
	a_preamble: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(dqs_oe) && !dq_oe) |=> dq_oe)
	else
	begin
		$error("preamble not followed by a data beat");
		fail_count++;
	end

	// Strobe parked low when not driven
	a_dqs_parked: assert property (@(posedge clk) disable iff (!arst_n) !dqs_oe |-> !dqs_out)
	else
	begin
		$error("dqs_out high while dqs_oe is low");
		fail_count++;
	end

endmodule

bind dram_burst_sched dram_model_props u_dram_model_props (
	.clk     (clk),
	.arst_n  (arst_n),
	.dq_oe   (dq_oe),
	.dqs_oe  (dqs_oe),
	.dqs_out (dqs_out)
);

// File: testbench/dram_model_tb.sv
// DRAM model testbench
`include "dram_cfg.svh"

module dram_model_tb;

	localparam int timeout_cycles = 64;

	// Command pins {cs_n, ras_n, cas_n, we_n}
	localparam logic [3:0] pins_read  = 4'b0101;
	localparam logic [3:0] pins_write = 4'b0100;
	localparam logic [3:0] pins_act   = 4'b0011;
	localparam logic [3:0] pins_mode  = 4'b0000;
	localparam logic [3:0] pins_idle  = 4'b1111;

	logic                    clk;
	logic                    arst_n;
	logic                    cs_n;
	logic                    ras_n;
	logic                    cas_n;
	logic                    we_n;
	logic [`DRAM_BANK_W-1:0] ba;
	logic [`DRAM_ADDR_W-1:0] addr;
	logic [`DRAM_DATA_W-1:0] dq_in;
	logic [`DRAM_ECC_W-1:0]  ecc_in;
	logic [`DRAM_DATA_W-1:0] dq_out;
	logic [`DRAM_ECC_W-1:0]  ecc_out;
	logic                    dq_oe;
	logic                    dqs_out;
	logic                    dqs_oe;

	// One read waiting for its beats
	typedef struct packed {
		logic [31:0] c_edge;
		logic [1:0]  bank;
		logic [3:0]  row;
		logic [5:0]  col;
		logic [31:0] bl;
		logic [31:0] rl;
	} read_req_t;

	read_req_t   read_q [$];
	int          reads_issued = 0;
	int          reads_checked = 0;
	int unsigned edge_cnt = 0;
	logic [31:0] rng_state = 32'd9;

	// Model of the memory and of the mode and row state
	logic [`DRAM_WORD_W-1:0] ref_mem [4096];
	logic [3:0]              open_row [4];
	int                      cur_bl;
	int                      cur_cas;
	int                      cur_align;
	int                      cur_rl;
	int                      cur_wl;

	dram_model_top u_dram_model_top (
		.clk     (clk),
		.arst_n  (arst_n),
		.cs_n    (cs_n),
		.ras_n   (ras_n),
		.cas_n   (cas_n),
		.we_n    (we_n),
		.ba      (ba),
		.addr    (addr),
		.dq_in   (dq_in),
		.ecc_in  (ecc_in),
		.dq_out  (dq_out),
		.ecc_out (ecc_out),
		.dq_oe   (dq_oe),
		.dqs_out (dqs_out),
		.dqs_oe  (dqs_oe)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Rising edges since start
	always @(posedge clk)
	begin
		edge_cnt <= edge_cnt + 1;
	end

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [11:0] mem_key(input logic [1:0] bank, input logic [3:0] row,
		input logic [5:0] col);
		return {bank, row, col};
	endfunction

	// Upper column bits stay while the low two wrap
	function automatic logic [5:0] beat_col(input logic [5:0] col, input logic [1:0] beat);
		return {col[5:2], col[1:0] + beat};
	endfunction

	function automatic logic [71:0] expected_word(input logic [1:0] bank,
		input logic [3:0] row, input logic [5:0] col, input logic [1:0] beat);
		return ref_mem[mem_key(bank, row, beat_col(col, beat))];
	endfunction

	task automatic next_word(output logic [71:0] w);
		rng_state = xorshift32(rng_state);
		w[31:0] = rng_state;
		rng_state = xorshift32(rng_state);
		w[63:32] = rng_state;
		rng_state = xorshift32(rng_state);
		w[71:64] = rng_state[7:0];
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string what, input logic [71:0] got,
		input logic [71:0] exp);
		stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
			$time, what, got, exp));
	endtask

	// --------------------
	// Stimulus
	// --------------------
	// One command for a single capture edge then back to idle
	task automatic issue_cmd(input logic [3:0] pins, input logic [1:0] bank,
		input logic [7:0] a, output int unsigned c_edge);
		@(negedge clk);
		{cs_n, ras_n, cas_n, we_n} = pins;
		ba   = bank;
		addr = a;
		@(negedge clk);
		c_edge = edge_cnt;
		{cs_n, ras_n, cas_n, we_n} = pins_idle;
	endtask

	task automatic activate(input logic [1:0] bank, input logic [3:0] row);
		int unsigned c;
		issue_cmd(pins_act, bank, {4'b0, row}, c);
		open_row[bank] = row;
	endtask

	task automatic mode_set(input logic [1:0] bank, input logic [7:0] a);
		int unsigned c;
		issue_cmd(pins_mode, bank, a, c);
		if (bank == 2'd0)
		begin
			case (a[2:0])
				3'd0: cur_bl = 1;
				3'd1: cur_bl = 2;
				default: cur_bl = 4;
			endcase
			cur_cas = int'(a[6:4]);
		end
		else if (bank == 2'd1)
		begin
			cur_align = int'(a[5:3]);
		end
		cur_rl = cur_cas + cur_align;
		cur_wl = cur_rl - 1;
	endtask

	// Beat n sampled at edge C + write_lat + n + 2
	task automatic write_burst(input logic [1:0] bank, input logic [5:0] col);
		int unsigned c;
		logic [71:0] w;
		issue_cmd(pins_write, bank, {2'b0, col}, c);
		repeat (cur_wl + 1) @(negedge clk);
		for (int n = 0; n < cur_bl; n++)
		begin
			next_word(w);
			dq_in  = w[63:0];
			ecc_in = w[71:64];
			ref_mem[mem_key(bank, open_row[bank], beat_col(col, 2'(n)))] = w;
			@(negedge clk);
		end
		// Noise after the burst must not land anywhere
		next_word(w);
		dq_in  = w[63:0];
		ecc_in = w[71:64];
	endtask

	task automatic wait_reads_done();
		for (int i = 0; i < timeout_cycles && reads_checked != reads_issued; i++)
		begin
			@(negedge clk);
		end
		if (reads_checked != reads_issued)
		begin
			stop_with_failure("Timeout: read burst check did not finish");
		end
	endtask

	task automatic read_burst(input logic [1:0] bank, input logic [5:0] col);
		int unsigned c;
		issue_cmd(pins_read, bank, {2'b0, col}, c);
		read_q.push_back('{c, bank, open_row[bank], col, cur_bl, cur_rl});
		reads_issued++;
		wait_reads_done();
	endtask

	// Read and write patterns with cs_n high
	task automatic deselected_access(input logic [1:0] bank, input logic [5:0] col);
		int unsigned c;
		logic [71:0] w;
		issue_cmd(pins_read | 4'b1000, bank, {2'b0, col}, c);
		issue_cmd(pins_write | 4'b1000, bank, {2'b0, col}, c);
		for (int i = 0; i < 12; i++)
		begin
			next_word(w);
			dq_in  = w[63:0];
			ecc_in = w[71:64];
			@(negedge clk);
		end
	endtask

	// --------------------
	// Compare process
	// --------------------
	initial
	begin : compare_proc
		read_req_t   req;
		int          waited;
		logic [71:0] exp;
		forever
		begin
			@(negedge clk);
			if (read_q.size() != 0)
			begin
				req = read_q.pop_front();
				waited = 0;
				while (!dqs_oe && !dq_oe && waited < timeout_cycles)
				begin
					@(negedge clk);
					waited++;
				end
				if (!dqs_oe && !dq_oe)
				begin
					stop_with_failure("Timeout: no read strobe after a read command");
				end
				// Preamble one cycle ahead of beat 0
				assert (edge_cnt == req.c_edge + req.rl + 1)
				else report_mismatch("preamble cycle", edge_cnt, req.c_edge + req.rl + 1);
				assert ({dq_oe, dqs_oe, dqs_out} == 3'b010)
				else report_mismatch("preamble dq_oe/dqs_oe/dqs_out", {dq_oe, dqs_oe, dqs_out},
					3'b010);
				for (int n = 0; n < req.bl; n++)
				begin
					@(negedge clk);
					exp = expected_word(req.bank, req.row, req.col, 2'(n));
					assert (edge_cnt == req.c_edge + req.rl + 2 + n)
					else report_mismatch("beat cycle", edge_cnt, req.c_edge + req.rl + 2 + n);
					assert (dq_oe && dqs_oe)
					else report_mismatch("beat dq_oe/dqs_oe", {dq_oe, dqs_oe}, 2'b11);
					// Strobe toggles from low so even beats see it high
					assert (dqs_out == (n % 2 == 0))
					else report_mismatch("beat dqs_out", dqs_out, (n % 2 == 0));
					assert (dq_out == exp[63:0])
					else report_mismatch("dq_out", dq_out, exp[63:0]);
					assert (ecc_out == exp[71:64])
					else report_mismatch("ecc_out", ecc_out, exp[71:64]);
				end
				@(negedge clk);
				assert ({dq_oe, dqs_oe, dqs_out} == 3'b000)
				else report_mismatch("after burst dq_oe/dqs_oe/dqs_out",
					{dq_oe, dqs_oe, dqs_out}, 3'b000);
				reads_checked++;
			end
			else if (arst_n)
			begin
				// Bus quiet with no read in flight
				assert ({dq_oe, dqs_oe, dqs_out} == 3'b000)
				else report_mismatch("idle dq_oe/dqs_oe/dqs_out", {dq_oe, dqs_oe, dqs_out},
					3'b000);
			end
		end
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		arst_n = 1'b0;
		{cs_n, ras_n, cas_n, we_n} = pins_idle;
		ba     = '0;
		addr   = '0;
		dq_in  = '0;
		ecc_in = '0;
		for (int i = 0; i < 4096; i++)
		begin
			ref_mem[i] = '0;
		end
		for (int b = 0; b < 4; b++)
		begin
			open_row[b] = 4'd0;
		end
		// Reset defaults of the mode registers
		cur_bl    = 4;
		cur_cas   = 2;
		cur_align = 0;
		cur_rl    = 2;
		cur_wl    = 1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Default mode round trip
		activate(2'd0, 4'h1);
		write_burst(2'd0, 6'h10);
		read_burst(2'd0, 6'h10);

		// Deselected commands leave bus and memory alone
		deselected_access(2'd0, 6'h10);
		read_burst(2'd0, 6'h10);

		// Wrapped start column
		write_burst(2'd0, 6'h2e);
		read_burst(2'd0, 6'h2e);
		read_burst(2'd0, 6'h2c);

		// Rows per bank
		activate(2'd1, 4'h5);
		write_burst(2'd1, 6'h10);
		read_burst(2'd1, 6'h10);
		read_burst(2'd0, 6'h10);
		activate(2'd1, 4'h9);
		read_burst(2'd1, 6'h10);
		write_burst(2'd1, 6'h10);
		read_burst(2'd1, 6'h10);
		activate(2'd1, 4'h5);
		read_burst(2'd1, 6'h10);
		read_burst(2'd0, 6'h10);

		// CAS 4 with bursts of 2 then alignment 3
		mode_set(2'd0, 8'h41);
		mode_set(2'd1, 8'h18);
		write_burst(2'd0, 6'h21);
		read_burst(2'd0, 6'h21);
		// Full burst at default mode shows two untouched words
		mode_set(2'd0, 8'h22);
		mode_set(2'd1, 8'h00);
		read_burst(2'd0, 6'h20);

		repeat (4) @(negedge clk);
		if (u_dram_model_top.u_dram_burst_sched.u_dram_model_props.fail_count == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			stop_with_failure("A strobe ordering property failed during the run");
		end
	end

endmodule

// File: verilog.f
+incdir+include
hdl/dram_mode_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/dram_array.sv
hdl/dram_cmd_decode.sv
hdl/dram_burst_sched.sv
hdl/dram_model_top.sv
testbench/dram_model_props.sv
testbench/dram_model_tb.sv

// File: Makefile
# Verilator build and run for the DRAM model

VERILATOR ?= verilator
TOP       ?= dram_model_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) include/dram_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
